/* compile.f */
source/cpuPkg.sv
source/alu.sv
source/registerFile.sv
source/immediateGen.sv
source/controlUnit.sv
source/datapath.sv
source/cpuTop.sv
verification/clockGen.sv
verification/cpuTb.sv

/* source/alu.sv */
module alu (
    input  cpuPkg::word  a,
    input  cpuPkg::word  b,
    input  cpuPkg::aluOp op,
    input  logic [2:0]   funct3,
    input  logic         funct7bit,
    output cpuPkg::word  result,
    output logic         taken
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        result = a + b;
        taken = 1'b0;
        case (op)
            cpuPkg::aluFunct: begin
                case (funct3)
                    3'b000:  result = funct7bit ? a - b : a + b;
                    3'b010:  result = {{(cpuPkg::xlen-1){1'b0}}, lessThan};
                    3'b100:  result = a ^ b;
                    3'b110:  result = a | b;
                    3'b111:  result = a & b;
                    default: result = a + b;
                endcase
            end
            cpuPkg::aluBranch: begin
                result = a - b;
                taken = funct3[0] ? (a != b) : (a == b); // bne or beq
            end
            default: result = a + b;
        endcase
    end

endmodule

/* source/controlUnit.sv */
module controlUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic [6:0]        opcode,
    input  logic              branchTaken,
    output cpuPkg::controlBus control,
    output logic              retire,
    output logic              halted
);

    cpuPkg::cpuState state;
    cpuPkg::cpuState nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuPkg::fetch1;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::fetch1:   nextState = cpuPkg::fetch2;
            cpuPkg::fetch2:   nextState = cpuPkg::fetch3;
            cpuPkg::fetch3:   nextState = cpuPkg::fetch4;
            cpuPkg::fetch4:   nextState = cpuPkg::decode;
            cpuPkg::decode:   nextState = (opcode == cpuPkg::opSystem) ? cpuPkg::halted
                                                                      : cpuPkg::execute1;
            cpuPkg::execute1: nextState = cpuPkg::execute2;
            cpuPkg::execute2: begin
                if (opcode == cpuPkg::opBranch) begin
                    nextState = cpuPkg::fetch1;
                end else if (opcode == cpuPkg::opLoad || opcode == cpuPkg::opStore) begin
                    nextState = cpuPkg::mem1;
                end else begin
                    nextState = cpuPkg::writeBack;
                end
            end
            cpuPkg::mem1:     nextState = cpuPkg::mem2;
            cpuPkg::mem2:     nextState = cpuPkg::mem3;
            cpuPkg::mem3:     nextState = cpuPkg::mem4;
            cpuPkg::mem4:     nextState = (opcode == cpuPkg::opStore) ? cpuPkg::fetch1
                                                                     : cpuPkg::writeBack;
            cpuPkg::writeBack: nextState = cpuPkg::fetch1;
            cpuPkg::halted:   nextState = cpuPkg::halted; // Only reset leaves
            default:          nextState = cpuPkg::fetch1;
        endcase
    end

    always_comb begin
        control = '0;
        // ALU idles on PC+4
        control.aluSrcA = cpuPkg::srcAPc;
        control.aluSrcB = cpuPkg::srcBFour;
        control.aluControl = cpuPkg::aluAdd;
        control.pcSource = cpuPkg::pcAluResult;
        case (state)
            cpuPkg::fetch1, cpuPkg::fetch2, cpuPkg::fetch3: control.memRead = 1'b1;
            cpuPkg::fetch4: begin
                control.memRead = 1'b1;
                control.irWrite = 1'b1;
            end
            cpuPkg::execute1, cpuPkg::execute2: begin
                case (opcode)
                    cpuPkg::opArith: begin
                        control.aluSrcA = cpuPkg::srcAReg;
                        control.aluSrcB = cpuPkg::srcBReg;
                        control.aluControl = cpuPkg::aluFunct;
                    end
                    cpuPkg::opArithImm: begin
                        control.aluSrcA = cpuPkg::srcAReg;
                        control.aluSrcB = cpuPkg::srcBImm;
                        control.aluControl = cpuPkg::aluFunct;
                    end
                    cpuPkg::opLoad, cpuPkg::opStore: begin
                        control.aluSrcA = cpuPkg::srcAReg;
                        control.aluSrcB = cpuPkg::srcBImm;
                    end
                    cpuPkg::opBranch: begin
                        if (state == cpuPkg::execute1) begin
                            // Target into ALUOut, PC steps to the PC+4 left by decode
                            control.aluSrcB = cpuPkg::srcBImm;
                            control.pcSource = cpuPkg::pcAluOut;
                            control.pcWrite = 1'b1;
                        end else begin
                            control.aluSrcA = cpuPkg::srcAReg;
                            control.aluSrcB = cpuPkg::srcBReg;
                            control.aluControl = cpuPkg::aluBranch;
                            control.pcSource = cpuPkg::pcAluOut;
                            control.pcWriteCond = 1'b1;
                        end
                    end
                    default: ; // Jumps keep the link value in ALUOut
                endcase
            end
            cpuPkg::mem1, cpuPkg::mem2, cpuPkg::mem3: begin
                control.iorD = 1'b1;
                control.aluSrcA = cpuPkg::srcAReg; // Hold the address in ALUOut
                control.aluSrcB = cpuPkg::srcBImm;
                control.memRead = (opcode == cpuPkg::opLoad);
            end
            cpuPkg::mem4: begin
                control.iorD = 1'b1;
                if (opcode == cpuPkg::opLoad) begin
                    control.aluSrcA = cpuPkg::srcAReg;
                    control.aluSrcB = cpuPkg::srcBImm;
                    control.memRead = 1'b1;
                    control.loadMdr = 1'b1;
                end else begin
                    control.memWrite = 1'b1; // Single strobe per store
                    control.pcWrite = 1'b1;
                end
            end
            cpuPkg::writeBack: begin
                control.pcWrite = 1'b1;
                control.memToReg = (opcode == cpuPkg::opLoad);
                case (opcode)
                    cpuPkg::opArith, cpuPkg::opArithImm, cpuPkg::opLoad: begin
                        control.regWrite = 1'b1;
                    end
                    cpuPkg::opJal: begin
                        control.regWrite = 1'b1;
                        control.aluSrcB = cpuPkg::srcBImm;
                    end
                    cpuPkg::opJalr: begin
                        control.regWrite = 1'b1;
                        control.aluSrcA = cpuPkg::srcAReg;
                        control.aluSrcB = cpuPkg::srcBImm;
                    end
                    default: ; // Unknown opcode just advances
                endcase
            end
            default: ;
        endcase
    end

    assign retire = (state == cpuPkg::writeBack)
        || (state == cpuPkg::execute2 && opcode == cpuPkg::opBranch)
        || (state == cpuPkg::mem4 && opcode == cpuPkg::opStore)
        || (state == cpuPkg::decode && opcode == cpuPkg::opSystem);

    assign halted = (state == cpuPkg::halted);

    memStrobesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(control.memRead && control.memWrite));

    haltIsFinal: assert property (@(posedge clk) disable iff (reset)
        state == cpuPkg::halted |=> state == cpuPkg::halted);

    // Compare result from the datapath must be resolved when it steers the PC
    branchResolved: assert property (@(posedge clk) disable iff (reset)
        control.pcWriteCond |-> !$isunknown(branchTaken));

endmodule

/* source/cpuPkg.sv */
package cpuPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word;
    typedef logic [4:0] regIndex;

    // Major opcodes of the supported subset
    localparam logic [6:0] opArith    = 7'b0110011;
    localparam logic [6:0] opArithImm = 7'b0010011;
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam logic [6:0] opStore    = 7'b0100011;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opSystem   = 7'b1110011;

    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01, // Equality compare, funct3 picks beq or bne
        aluFunct  = 2'b10
    } aluOp;

    typedef enum logic {
        srcAPc  = 1'b0,
        srcAReg = 1'b1
    } srcA;

    typedef enum logic [1:0] {
        srcBReg  = 2'b00,
        srcBFour = 2'b01,
        srcBImm  = 2'b10
    } srcB;

    typedef enum logic {
        pcAluResult = 1'b0,
        pcAluOut    = 1'b1
    } pcSel;

    typedef enum logic [3:0] {
        fetch1, fetch2, fetch3, fetch4,
        decode,
        execute1, execute2,
        mem1, mem2, mem3, mem4,
        writeBack,
        halted
    } cpuState;

    typedef struct packed {
        logic pcWrite;
        logic pcWriteCond; // PC load only when the branch is taken
        logic iorD;        // Address from ALUOut instead of PC
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic irWrite;
        logic regWrite;
        srcA  aluSrcA;
        srcB  aluSrcB;
        aluOp aluControl;
        pcSel pcSource;
        logic loadMdr;
    } controlBus;

    typedef struct packed {
        word  address;
        word  writeData;
        logic read;
        logic write;
    } memRequest;

endpackage

/* source/cpuTop.sv */
module cpuTop (
    input  logic              clk,
    input  logic              reset,
    input  cpuPkg::word       memReadData,
    output cpuPkg::memRequest memOut,
    output logic              retire,
    output logic              halted
);

    cpuPkg::controlBus control;
    logic [6:0] opcode;
    logic branchTaken;

    controlUnit u_controlUnit (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .branchTaken(branchTaken),
        .control    (control),
        .retire     (retire),
        .halted     (halted)
    );

    // Single memory port shared by fetch and data access
    datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .control    (control),
        .memReadData(memReadData),
        .mem        (memOut),
        .opcode     (opcode),
        .branchTaken(branchTaken)
    );

endmodule

/* source/datapath.sv */
module datapath (
    input  logic              clk,
    input  logic              reset,
    input  cpuPkg::controlBus control,
    input  cpuPkg::word       memReadData,
    output cpuPkg::memRequest mem,
    output logic [6:0]        opcode,
    output logic              branchTaken
);

    cpuPkg::word pc;
    cpuPkg::word ir;
    cpuPkg::word regA;
    cpuPkg::word regB;
    cpuPkg::word aluOut;
    cpuPkg::word mdr;
    cpuPkg::word readDataA;
    cpuPkg::word readDataB;
    cpuPkg::word immediate;
    cpuPkg::word aluA;
    cpuPkg::word aluB;
    cpuPkg::word aluResult;
    cpuPkg::word writeData;
    cpuPkg::word pcNext;
    cpuPkg::regIndex rs1;
    cpuPkg::regIndex rs2;
    cpuPkg::regIndex rd;
    logic funct7bit;

    assign opcode = ir[6:0];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];
    assign rd = ir[11:7];
    assign funct7bit = ir[30] && (opcode == cpuPkg::opArith); // sub only, not addi

    registerFile u_registerFile (
        .clk        (clk),
        .readIndexA (rs1),
        .readIndexB (rs2),
        .writeIndex (rd),
        .writeEnable(control.regWrite),
        .writeData  (writeData),
        .readDataA  (readDataA),
        .readDataB  (readDataB)
    );

    immediateGen u_immediateGen (
        .instruction(ir),
        .immediate  (immediate)
    );

    assign aluA = (control.aluSrcA == cpuPkg::srcAReg) ? regA : pc;

    always_comb begin
        case (control.aluSrcB)
            cpuPkg::srcBReg:  aluB = regB;
            cpuPkg::srcBFour: aluB = cpuPkg::xlen'(4);
            default:          aluB = immediate;
        endcase
    end

    alu u_alu (
        .a        (aluA),
        .b        (aluB),
        .op       (control.aluControl),
        .funct3   (ir[14:12]),
        .funct7bit(funct7bit),
        .result   (aluResult),
        .taken    (branchTaken)
    );

    assign writeData = control.memToReg ? mdr : aluOut;
    assign pcNext = (control.pcSource == cpuPkg::pcAluOut) ? aluOut : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (control.pcWrite || (control.pcWriteCond && branchTaken)) begin
            pc <= {pcNext[cpuPkg::xlen-1:1], 1'b0}; // jalr clears bit 0
        end
    end

    always_ff @(posedge clk) begin
        regA <= readDataA;
        regB <= readDataB;
        aluOut <= aluResult;
        if (control.irWrite) begin
            ir <= memReadData;
        end
        if (control.loadMdr) begin
            mdr <= memReadData;
        end
    end

    always_comb begin
        mem.address = control.iorD ? aluOut : pc;
        mem.writeData = regB;
        mem.read = control.memRead;
        mem.write = control.memWrite;
    end

endmodule

/* source/immediateGen.sv */
module immediateGen (
    input  cpuPkg::word instruction,
    output cpuPkg::word immediate
);

    logic [6:0] opcode;
    logic sign;

    assign opcode = instruction[6:0];
    assign sign = instruction[31];

    always_comb begin
        case (opcode)
            cpuPkg::opStore: immediate = {{(cpuPkg::xlen-12){sign}},
                instruction[31:25], instruction[11:7]};
            cpuPkg::opBranch: immediate = {{(cpuPkg::xlen-13){sign}}, sign,
                instruction[7], instruction[30:25], instruction[11:8], 1'b0};
            cpuPkg::opJal: immediate = {{(cpuPkg::xlen-21){sign}}, sign,
                instruction[19:12], instruction[20], instruction[30:21], 1'b0};
            default: immediate = {{(cpuPkg::xlen-12){sign}}, instruction[31:20]}; // I format
        endcase
    end

endmodule

/* source/registerFile.sv */
module registerFile (
    input  logic            clk,
    input  cpuPkg::regIndex readIndexA,
    input  cpuPkg::regIndex readIndexB,
    input  cpuPkg::regIndex writeIndex,
    input  logic            writeEnable,
    input  cpuPkg::word     writeData,
    output cpuPkg::word     readDataA,
    output cpuPkg::word     readDataB
);

    cpuPkg::word regs [32];

    always_ff @(posedge clk) begin
        regs[0] <= '0; // x0 held at zero
        if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    assign readDataA = regs[readIndexA];
    assign readDataB = regs[readIndexB];

    // Holds even right after a write aimed at x0
    zeroRegisterReads: assert property (@(posedge clk)
        (readIndexA == '0 |-> readDataA == '0) and (readIndexB == '0 |-> readDataB == '0));

endmodule

/* verification/clockGen.sv */
module clockGen #(
    parameter int period = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

/* verification/cpuTb.sv */
module cpuTb;

    localparam int period = 4;
    localparam int maxCycles = 600; // About 1.5 times the program's cycle count

    logic clk;
    logic reset;
    cpuPkg::word memReadData;
    cpuPkg::memRequest memOut;
    logic retire;
    logic halted;

    cpuPkg::word mem [256];
    cpuPkg::word image [256];
    int testOf [256];
    cpuPkg::word instPc [64];
    int instTest [64];
    int instCycles [64];
    cpuPkg::word storeAddr [64];
    cpuPkg::word storeData [64];
    int numInstr;
    int numStores;
    int errors [7];
    string testName [7];
    int seed = 22049;
    int emitIdx;
    int cycle;
    int fetchStart;
    int instIdx;
    int storeIdx;
    logic expectFetch;

    clockGen #(.period(period)) u_clockGen (.clk(clk));

    cpuTop u_cpuTop (
        .clk        (clk),
        .reset      (reset),
        .memReadData(memReadData),
        .memOut     (memOut),
        .retire     (retire),
        .halted     (halted)
    );

    assign memReadData = mem[memOut.address[9:2]];

    function automatic cpuPkg::word iEnc(cpuPkg::word imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic cpuPkg::word rEnc(logic sub, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, cpuPkg::opArith};
    endfunction

    function automatic cpuPkg::word sEnc(cpuPkg::word imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic cpuPkg::word bEnc(cpuPkg::word imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpuPkg::opBranch};
    endfunction

    function automatic cpuPkg::word jEnc(cpuPkg::word imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpuPkg::opJal};
    endfunction

    function automatic cpuPkg::word arith(logic [2:0] f3, logic sub, cpuPkg::word a,
                                          cpuPkg::word b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(int test, cpuPkg::word ins);
        image[emitIdx] = ins;
        testOf[emitIdx] = test;
        emitIdx++;
    endtask

    // Instruction-level reference run over the program image
    task automatic runModel();
        cpuPkg::word m [256];
        cpuPkg::word x [32];
        cpuPkg::word pc;
        cpuPkg::word ins;
        cpuPkg::word nextPc;
        cpuPkg::word addr;
        cpuPkg::word immI;
        cpuPkg::word immS;
        cpuPkg::word immB;
        cpuPkg::word immJ;
        logic done;
        m = image;
        x = '{default: '0};
        pc = '0;
        done = 1'b0;
        numInstr = 0;
        numStores = 0;
        while (!done) begin
            ins = m[pc[9:2]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            instPc[numInstr] = pc;
            instTest[numInstr] = testOf[pc[9:2]];
            nextPc = pc + 4;
            case (ins[6:0])
                cpuPkg::opArith: begin
                    instCycles[numInstr] = 8;
                    x[ins[11:7]] = arith(ins[14:12], ins[30], x[ins[19:15]], x[ins[24:20]]);
                end
                cpuPkg::opArithImm: begin
                    instCycles[numInstr] = 8;
                    x[ins[11:7]] = arith(ins[14:12], 1'b0, x[ins[19:15]], immI);
                end
                cpuPkg::opLoad: begin
                    instCycles[numInstr] = 12;
                    addr = x[ins[19:15]] + immI;
                    x[ins[11:7]] = m[addr[9:2]];
                end
                cpuPkg::opStore: begin
                    instCycles[numInstr] = 11;
                    addr = x[ins[19:15]] + immS;
                    m[addr[9:2]] = x[ins[24:20]];
                    storeAddr[numStores] = addr;
                    storeData[numStores] = x[ins[24:20]];
                    numStores++;
                end
                cpuPkg::opBranch: begin
                    instCycles[numInstr] = 7;
                    if ((x[ins[19:15]] == x[ins[24:20]]) ^ ins[12]) begin
                        nextPc = pc + immB;
                    end
                end
                cpuPkg::opJal: begin
                    instCycles[numInstr] = 8;
                    x[ins[11:7]] = pc + 4;
                    nextPc = pc + immJ;
                end
                cpuPkg::opJalr: begin
                    instCycles[numInstr] = 8;
                    nextPc = (x[ins[19:15]] + immI) & ~32'd1;
                    x[ins[11:7]] = pc + 4;
                end
                default: begin
                    instCycles[numInstr] = 5; // ecall
                    done = 1'b1;
                end
            endcase
            x[0] = '0;
            pc = nextPc;
            numInstr++;
        end
    endtask

    task automatic buildProgram();
        cpuPkg::word p;
        for (int i = 0; i < 256; i++) begin
            image[i] = 32'hA5A50000 + i;
            testOf[i] = 6;
        end
        image[128] = $random(seed);
        image[129] = $random(seed);
        image[130] = $random(seed);
        emitIdx = 0;
        emit(2, iEnc(32'h200, 0, 3'b010, 1, cpuPkg::opLoad));
        emit(2, iEnc(32'h204, 0, 3'b010, 2, cpuPkg::opLoad));
        emit(2, rEnc(0, 2, 1, 3'b000, 3));
        emit(2, rEnc(1, 2, 1, 3'b000, 4));
        emit(2, rEnc(0, 2, 1, 3'b111, 5));
        emit(2, rEnc(0, 2, 1, 3'b110, 6));
        emit(2, rEnc(0, 2, 1, 3'b100, 7));
        emit(2, rEnc(0, 2, 1, 3'b010, 8));
        emit(2, iEnc($random(seed), 1, 3'b000, 9, cpuPkg::opArithImm));
        emit(2, iEnc($random(seed), 1, 3'b111, 10, cpuPkg::opArithImm));
        emit(2, iEnc($random(seed), 1, 3'b110, 11, cpuPkg::opArithImm));
        emit(2, iEnc($random(seed), 1, 3'b100, 12, cpuPkg::opArithImm));
        emit(2, iEnc($random(seed), 1, 3'b010, 13, cpuPkg::opArithImm));
        emit(2, rEnc(0, 2, 1, 3'b000, 0)); // Write to x0 is dropped
        for (int r = 0; r < 14; r++) begin
            emit(2, sEnc(32'h300 + 4 * r, r, 0));
        end
        emit(3, iEnc(32'h208, 0, 3'b010, 14, cpuPkg::opLoad));
        emit(3, sEnc(32'h380, 14, 0));
        emit(4, iEnc(32'h55, 0, 3'b000, 15, cpuPkg::opArithImm));
        emit(4, bEnc(8, 1, 1, 3'b000)); // Taken so the next store is skipped
        emit(4, sEnc(32'h384, 15, 0));
        emit(4, bEnc(8, 1, 1, 3'b001));
        emit(4, sEnc(32'h388, 15, 0));
        emit(5, jEnc(8, 16));
        emit(5, sEnc(32'h3F0, 0, 0));
        emit(5, sEnc(32'h38C, 16, 0));
        p = 4 * emitIdx;
        emit(5, iEnc(p + 12, 0, 3'b000, 17, cpuPkg::opArithImm));
        emit(5, iEnc(0, 17, 3'b000, 18, cpuPkg::opJalr));
        emit(5, sEnc(32'h3F4, 0, 0));
        emit(5, sEnc(32'h390, 18, 0));
        emit(6, 32'h00000073);
    endtask

    task automatic reportFailure(int test, string msg);
        // Activity past the last instruction belongs to the halt test
        if (test < 1 || test > 6) begin
            test = 6;
        end
        errors[test]++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cycle <= 0;
            fetchStart <= 0;
            instIdx <= 0;
            storeIdx <= 0;
            expectFetch <= 1'b1;
        end else begin
            cycle <= cycle + 1;
            if (expectFetch && memOut.read) begin
                fetchStart <= cycle;
                expectFetch <= 1'b0;
            end
            if (retire) begin
                instIdx <= instIdx + 1;
                expectFetch <= 1'b1;
            end
            if (memOut.write) begin
                mem[memOut.address[9:2]] <= memOut.writeData;
                storeIdx <= storeIdx + 1;
            end
        end
    end

    resetState: assert property (@(posedge clk) $fell(reset) |->
        memOut.read && !memOut.write && !halted && memOut.address == '0)
        else reportFailure(1, "outputs wrong on the first cycle after reset");

    storeMatches: assert property (@(posedge clk) disable iff (reset)
        memOut.write |-> storeIdx < numStores && memOut.address == storeAddr[storeIdx]
            && memOut.writeData == storeData[storeIdx])
        else reportFailure(instTest[$sampled(instIdx)], $sformatf("store of %h to %h not expected",
            $sampled(memOut.writeData), $sampled(memOut.address)));

    fetchAddress: assert property (@(posedge clk) disable iff (reset)
        expectFetch && memOut.read |-> memOut.address == instPc[instIdx])
        else reportFailure(instTest[$sampled(instIdx)], $sformatf("fetch from %h, expected %h",
            $sampled(memOut.address), instPc[$sampled(instIdx)]));

    retireTiming: assert property (@(posedge clk) disable iff (reset)
        retire |-> cycle - fetchStart + 1 == instCycles[instIdx])
        else reportFailure(instTest[$sampled(instIdx)], $sformatf("retire after %0d cycles at %h",
            $sampled(cycle) - $sampled(fetchStart) + 1, instPc[$sampled(instIdx)]));

    haltTiming: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) |-> cycle - fetchStart == 5 && instIdx == numInstr)
        else reportFailure(6, "halt came late or after the wrong retire count");

    haltHolds: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else reportFailure(6, "halted dropped");

    noFetchWhenHalted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !memOut.read)
        else reportFailure(6, "memory read while halted");

    initial begin : watchdog
        #(maxCycles * period);
        $display("Timeout, the core did not halt within %0d cycles", maxCycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int failedTests;
        reset = 1'b1;
        failedTests = 0;
        testName = '{"", "reset", "arithmetic", "load/store", "branches", "jumps", "halt"};
        errors = '{default: 0};
        buildProgram();
        runModel();
        mem = image;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        wait (halted === 1'b1);
        repeat (8) @(posedge clk);
        if (storeIdx != numStores) begin
            reportFailure(4, $sformatf("%0d stores seen, %0d expected", storeIdx, numStores));
        end
        for (int t = 1; t < 7; t++) begin
            $display("Test %0d %s: %s (%0d errors)", t, testName[t],
                errors[t] == 0 ? "ok" : "failed", errors[t]);
            if (errors[t] != 0) begin
                failedTests++;
            end
        end
        $display("Tests passed %0d, failed %0d", 6 - failedTests, failedTests);
        if (failedTests == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
